/* all.f */
hdl/memtest_pkg.sv
hdl/uart_pkg.sv
hdl/memtest_ctrl.sv
hdl/burst_pattern.sv
hdl/readback_checker.sv
hdl/uart_tx.sv
hdl/sdram_memtest_top.sv
sim/memtest_sva.sv
sim/tb_sdram_memtest.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SDRAM burst tester testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sdram_memtest \
    -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q '\*\*\* PASSED \*\*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/tb_sdram_memtest.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_memtest;

    localparam int CLK_NS       = 10;
    localparam int BIT_NS       = int'(uart_pkg::BAUD_DIVISOR) * CLK_NS;  // One UART bit.
    localparam int END_TIMEOUT  = 500000;  // Cycles. Longer than 32 frames.
    localparam int QUIET_CYCLES = 13000;   // More than one frame.
    localparam int NUM_ROWS     = 4;

    //////////////////// Stimulus table.
    string       row_name        [NUM_ROWS] = '{"clean_lat1", "clean_lat20", "fault_b0_l1",
                                                "fault_b2_l3"};
    int unsigned row_max_lat     [NUM_ROWS] = '{1, 20, 5, 3};
    int          row_fault_burst [NUM_ROWS] = '{-1, -1, 0, 2};  // -1 for no fault.
    int          row_fault_lane  [NUM_ROWS] = '{0, 0, 1, 3};
    int          row_exp_bytes   [NUM_ROWS] = '{32, 32, 2, 22};  // 8b + 2k on a fault.
    logic        row_exp_err     [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};

    logic        clk_133MHz_210 = 1'b0;
    logic        rst_n;
    logic        mem_wr_done;
    logic        mem_rd_done;
    logic [15:0] mem_rdata0;
    logic [15:0] mem_rdata1;
    logic [15:0] mem_rdata2;
    logic [15:0] mem_rdata3;
    wire         mem_wr_req;
    wire         mem_rd_req;
    wire  [23:0] mem_addr;
    wire  [15:0] mem_wdata0;
    wire  [15:0] mem_wdata1;
    wire  [15:0] mem_wdata2;
    wire  [15:0] mem_wdata3;
    wire         uart_txd;
    wire         err_led;
    wire         test_done;

    logic [15:0] mem_store [16];       // Whole test region.
    logic [7:0]  rx_bytes [$];         // Bytes seen on the line.
    logic [7:0]  ref_stream [$];       // Stream of the first clean row.
    int          cur_row;
    int unsigned cur_max_lat;
    int          wr_count;             // Writes started in this row.
    int          rd_count;
    int          check_cnt = 0;
    int          err_cnt   = 0;

    always #(CLK_NS / 2) clk_133MHz_210 = ~clk_133MHz_210;

    sdram_memtest_top #(.REGION_WORDS(24'd16), .PAUSE_CYCLES(200)) dut (.*);

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Burst n carries word n + k in lane k. High byte goes first.
    function automatic logic [7:0] expected_byte(input int idx);
        logic [15:0] word;
        word = 16'(idx / 8 + (idx % 8) / 2);
        return (idx % 2 == 0) ? word[15:8] : word[7:0];
    endfunction

    function automatic logic [15:0] read_lane(input int base, input int k);
        logic [15:0] word;
        word = mem_store[base + k];
        if (rd_count - 1 == row_fault_burst[cur_row] && k == row_fault_lane[cur_row]) begin
            word = word ^ 16'h0001;  // Flip one bit in the low byte of the chosen lane.
        end
        return word;
    endfunction

    //////////////////// Memory model.
    initial begin : memory_model
        int wr_left;
        int rd_left;
        int base;
        wr_left = 0;
        rd_left = 0;
        mem_wr_done = 1'b0;
        mem_rd_done = 1'b0;
        {mem_rdata0, mem_rdata1, mem_rdata2, mem_rdata3} = '0;
        forever begin
            @(posedge clk_133MHz_210);
            #1;
            mem_wr_done = 1'b0;  // Done is a one-cycle pulse.
            mem_rd_done = 1'b0;
            base = int'(mem_addr);
            if (!rst_n) begin
                wr_left = 0;
                rd_left = 0;
            end else if (wr_left > 0) begin
                wr_left--;
                if (wr_left == 0) begin
                    mem_store[base]     = mem_wdata0;
                    mem_store[base + 1] = mem_wdata1;
                    mem_store[base + 2] = mem_wdata2;
                    mem_store[base + 3] = mem_wdata3;
                    mem_wr_done = 1'b1;
                end
            end else if (rd_left > 0) begin
                rd_left--;
                if (rd_left == 0) begin
                    mem_rdata0  = read_lane(base, 0);
                    mem_rdata1  = read_lane(base, 1);
                    mem_rdata2  = read_lane(base, 2);
                    mem_rdata3  = read_lane(base, 3);
                    mem_rd_done = 1'b1;
                end
            end else if (mem_wr_req) begin
                check_value($sformatf("%s wr addr", row_name[cur_row]),
                            32'(4 * wr_count), 32'(mem_addr));
                check_value("wdata0", 32'(wr_count), 32'(mem_wdata0));
                check_value("wdata1", 32'(wr_count + 1), 32'(mem_wdata1));
                check_value("wdata2", 32'(wr_count + 2), 32'(mem_wdata2));
                check_value("wdata3", 32'(wr_count + 3), 32'(mem_wdata3));
                wr_count++;
                wr_left = 1 + int'($urandom % cur_max_lat);  // Back-pressure.
            end else if (mem_rd_req) begin
                check_value($sformatf("%s rd addr", row_name[cur_row]),
                            32'(4 * rd_count), 32'(mem_addr));
                check_value("read after write", 32'(wr_count), 32'(rd_count + 1));
                rd_count++;
                rd_left = 1 + int'($urandom % cur_max_lat);
            end
        end
    end

    //////////////////// UART receiver.
    task automatic receive_frame();
        logic [7:0] data;
        int         i;
        #(BIT_NS / 2 - CLK_NS / 2);  // Middle of the start bit.
        check_value("start bit", 32'd0, 32'(uart_txd));
        for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
            #(BIT_NS);
            data[i] = uart_txd;  // LSB first.
        end
        for (i = 0; i < uart_pkg::STOP_BITS; i++) begin
            #(BIT_NS);
            check_value("stop bit", 32'd1, 32'(uart_txd));
        end
        rx_bytes.push_back(data);
    endtask

    initial begin : uart_receiver
        forever begin
            @(negedge clk_133MHz_210);
            if (rst_n && uart_txd === 1'b0) begin
                receive_frame();
            end
        end
    end

    //////////////////// Stimulus.
    initial begin : stimulus
        int   row;
        int   i;
        int   cycles;
        logic ended;
        logic timed_out;
        void'($urandom(88));
        rst_n     = 1'b0;
        timed_out = 1'b0;
        for (row = 0; row < NUM_ROWS && !timed_out; row++) begin
            cur_row     = row;
            cur_max_lat = row_max_lat[row];
            for (i = 0; i < 16; i++) begin
                mem_store[i] = 16'hA5A5 ^ 16'(i * 257);  // Stale data unlike any pattern.
            end
            rx_bytes.delete();
            wr_count = 0;
            rd_count = 0;
            @(posedge clk_133MHz_210);
            #1;
            rst_n = 1'b0;
            repeat (5) @(posedge clk_133MHz_210);
            #1;
            check_value("reset wr_req", 32'd0, 32'(mem_wr_req));
            check_value("reset rd_req", 32'd0, 32'(mem_rd_req));
            check_value("reset txd", 32'd1, 32'(uart_txd));
            check_value("reset err_led", 32'd0, 32'(err_led));
            check_value("reset test_done", 32'd0, 32'(test_done));
            rst_n = 1'b1;

            ended = 1'b0;
            for (cycles = 0; cycles < END_TIMEOUT && !ended; cycles++) begin
                @(posedge clk_133MHz_210);
                #1;
                ended = test_done | err_led;
            end
            if (!ended) begin
                $display("timeout: %s reached neither test_done nor err_led", row_name[row]);
                err_cnt++;
                timed_out = 1'b1;
            end else begin
                repeat (QUIET_CYCLES) @(posedge clk_133MHz_210);  // Nothing may follow.
                #1;
                check_value($sformatf("%s err_led", row_name[row]),
                            32'(row_exp_err[row]), 32'(err_led));
                check_value($sformatf("%s test_done", row_name[row]),
                            32'(!row_exp_err[row]), 32'(test_done));
                check_value($sformatf("%s byte count", row_name[row]),
                            32'(row_exp_bytes[row]), 32'(rx_bytes.size()));
                for (i = 0; i < rx_bytes.size(); i++) begin
                    check_value($sformatf("%s byte %0d", row_name[row], i),
                                32'(expected_byte(i)), 32'(rx_bytes[i]));
                end
                check_value($sformatf("%s writes", row_name[row]),
                            32'(row_exp_bytes[row] / 8 + (row_exp_err[row] ? 1 : 0)),
                            32'(wr_count));
                check_value($sformatf("%s reads", row_name[row]), 32'(wr_count),
                            32'(rd_count));
                if (!row_exp_err[row]) begin
                    if (ref_stream.size() == 0) begin
                        ref_stream = rx_bytes;
                    end else begin
                        for (i = 0; i < rx_bytes.size() && i < ref_stream.size(); i++) begin
                            check_value($sformatf("%s same stream %0d", row_name[row], i),
                                        32'(ref_stream[i]), 32'(rx_bytes[i]));
                        end
                    end
                end
            end
        end
        check_value("assertion failures", 32'd0, 32'(dut.u_memtest_sva.fail_cnt));
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/memtest_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module memtest_sva (
    input wire clk_133MHz_210,
    input wire rst_n,
    input wire mem_wr_req,
    input wire mem_rd_req,
    input wire mem_wr_done,
    input wire mem_rd_done,
    input wire err_led,
    input wire test_done
);

    int fail_cnt = 0;  // Failed assertions so far.

    //////////////////// Memory port.
    req_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_wr_req && mem_rd_req))
        else begin
            $error("write and read request high together");
            fail_cnt++;
        end

    // Request stays up until done is seen.
    wr_req_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_wr_req && !mem_wr_done |=> mem_wr_req)
        else begin
            $error("write request dropped before its done pulse");
            fail_cnt++;
        end

    rd_req_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_rd_req && !mem_rd_done |=> mem_rd_req)
        else begin
            $error("read request dropped before its done pulse");
            fail_cnt++;
        end

    //////////////////// Status.
    status_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(err_led && test_done))
        else begin
            $error("err_led and test_done high together");
            fail_cnt++;
        end

endmodule

bind sdram_memtest_top memtest_sva u_memtest_sva (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .mem_wr_req     (mem_wr_req),
    .mem_rd_req     (mem_rd_req),
    .mem_wr_done    (mem_wr_done),
    .mem_rd_done    (mem_rd_done),
    .err_led        (err_led),
    .test_done      (test_done)
);

`default_nettype wire

/* hdl/sdram_memtest_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_memtest_top #(
    parameter logic [memtest_pkg::ADDR_W-1:0] REGION_WORDS = memtest_pkg::DEFAULT_REGION_WORDS,
    parameter int unsigned PAUSE_CYCLES = memtest_pkg::DEFAULT_PAUSE_CYCLES
) (
    input  wire                             clk_133MHz_210,
    input  wire                             rst_n,
    // Memory port.
    output wire                             mem_wr_req,
    output wire                             mem_rd_req,
    output wire  [memtest_pkg::ADDR_W-1:0]  mem_addr,
    output wire  [memtest_pkg::WORD_W-1:0]  mem_wdata0,
    output wire  [memtest_pkg::WORD_W-1:0]  mem_wdata1,
    output wire  [memtest_pkg::WORD_W-1:0]  mem_wdata2,
    output wire  [memtest_pkg::WORD_W-1:0]  mem_wdata3,
    input  wire                             mem_wr_done,
    input  wire                             mem_rd_done,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata0,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata1,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata2,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata3,
    // Status.
    output wire                             uart_txd,
    output wire                             err_led,
    output wire                             test_done
);

    wire       advance;     // ctrl to pattern.
    wire       last_burst;  // pattern to ctrl.
    wire [2:0] byte_idx;
    wire       word_ok;
    wire [7:0] tx_byte;
    wire       tx_start;
    wire       tx_busy;

    //////////////////// Sequencing.
    memtest_ctrl #(.PAUSE_CYCLES(PAUSE_CYCLES)) u_ctrl (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_wr_done    (mem_wr_done),
        .mem_rd_done    (mem_rd_done),
        .word_ok        (word_ok),
        .last_burst     (last_burst),
        .tx_busy        (tx_busy),
        .mem_wr_req     (mem_wr_req),
        .mem_rd_req     (mem_rd_req),
        .advance        (advance),
        .byte_idx       (byte_idx),
        .tx_start       (tx_start),
        .err_led        (err_led),
        .test_done      (test_done)
    );

    burst_pattern #(.REGION_WORDS(REGION_WORDS)) u_pattern (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .advance        (advance),
        .mem_addr       (mem_addr),
        .mem_wdata0     (mem_wdata0),
        .mem_wdata1     (mem_wdata1),
        .mem_wdata2     (mem_wdata2),
        .mem_wdata3     (mem_wdata3),
        .last_burst     (last_burst)
    );

    //////////////////// Check and report.
    readback_checker u_checker (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_rd_done    (mem_rd_done),
        .mem_rdata0     (mem_rdata0),
        .mem_rdata1     (mem_rdata1),
        .mem_rdata2     (mem_rdata2),
        .mem_rdata3     (mem_rdata3),
        .mem_wdata0     (mem_wdata0),  // Expected values from the pattern.
        .mem_wdata1     (mem_wdata1),
        .mem_wdata2     (mem_wdata2),
        .mem_wdata3     (mem_wdata3),
        .byte_idx       (byte_idx),
        .word_ok        (word_ok),
        .tx_byte        (tx_byte)
    );

    uart_tx u_uart (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .uart_txd       (uart_txd),
        .tx_busy        (tx_busy)
    );

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire                          clk_133MHz_210,
    input  wire                          rst_n,
    input  wire                          tx_start,   // Load and go.
    input  wire  [uart_pkg::DATA_BITS-1:0] tx_byte,
    output logic                         uart_txd,   // Idles high.
    output logic                         tx_busy
);

    logic [uart_pkg::FRAME_BITS-1:0] frame_q;   // Bit 0 is on the wire.
    logic [10:0]                     baud_cnt;  // Cycles within a bit.
    logic [3:0]                      bit_cnt;   // Bit of frame.
    logic                            bit_end;

    assign bit_end = (baud_cnt == uart_pkg::BAUD_DIVISOR - 11'd1);

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame_q  <= '1;
            baud_cnt <= 11'd0;
            bit_cnt  <= 4'd0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Stop bits, data, start bit.
                frame_q  <= {{uart_pkg::STOP_BITS{1'b1}}, tx_byte, 1'b0};
                baud_cnt <= 11'd0;
                bit_cnt  <= 4'd0;
                tx_busy  <= 1'b1;
            end
        end else if (bit_end) begin
            baud_cnt <= 11'd0;
            if (bit_cnt == 4'(uart_pkg::FRAME_BITS - 1)) begin
                tx_busy  <= 1'b0;  // Last stop bit done.
            end else begin
                frame_q  <= {1'b1, frame_q[uart_pkg::FRAME_BITS-1:1]};  // Next bit onto the line.
                bit_cnt  <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 11'd1;
        end
    end

    // Ones shift in behind the frame, so the line rests high.
    assign uart_txd = frame_q[0];

endmodule

`default_nettype wire

/* hdl/readback_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module readback_checker (
    input  wire                             clk_133MHz_210,
    input  wire                             rst_n,
    input  wire                             mem_rd_done,  // Capture strobe.
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata0,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata1,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata2,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_rdata3,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_wdata0,   // Expected lanes.
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_wdata1,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_wdata2,
    input  wire  [memtest_pkg::WORD_W-1:0]  mem_wdata3,
    input  wire  [2:0]                      byte_idx,
    output logic                            word_ok,
    output logic [7:0]                      tx_byte
);

    logic [memtest_pkg::WORD_W-1:0] rd_word [memtest_pkg::BURST_WORDS];  // Captured burst.
    logic [memtest_pkg::WORD_W-1:0] wr_word [memtest_pkg::BURST_WORDS];
    logic [1:0]                     word_sel;
    logic [memtest_pkg::WORD_W-1:0] sel_word;

    //////////////////// Capture.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            rd_word <= '{default: '0};
        end else if (mem_rd_done) begin
            rd_word <= '{mem_rdata0, mem_rdata1, mem_rdata2, mem_rdata3};
        end
    end

    assign wr_word[0] = mem_wdata0;
    assign wr_word[1] = mem_wdata1;
    assign wr_word[2] = mem_wdata2;
    assign wr_word[3] = mem_wdata3;

    //////////////////// Select and compare.
    assign word_sel = byte_idx[2:1];    // Two bytes per word.
    assign sel_word = rd_word[word_sel];

    // Full word compare, not just the byte.
    assign word_ok = (sel_word == wr_word[word_sel]);

    // Even index takes the high byte.
    assign tx_byte = byte_idx[0] ? sel_word[7:0] : sel_word[memtest_pkg::WORD_W-1 -: 8];

endmodule

`default_nettype wire

/* hdl/burst_pattern.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_pattern #(
    parameter logic [memtest_pkg::ADDR_W-1:0] REGION_WORDS = memtest_pkg::DEFAULT_REGION_WORDS
) (
    input  wire                             clk_133MHz_210,
    input  wire                             rst_n,
    input  wire                             advance,     // Next burst.
    output logic [memtest_pkg::ADDR_W-1:0]  mem_addr,
    output logic [memtest_pkg::WORD_W-1:0]  mem_wdata0,
    output logic [memtest_pkg::WORD_W-1:0]  mem_wdata1,
    output logic [memtest_pkg::WORD_W-1:0]  mem_wdata2,
    output logic [memtest_pkg::WORD_W-1:0]  mem_wdata3,
    output logic                            last_burst
);

    logic [memtest_pkg::ADDR_W-1:0] burst_addr;  // First word of burst.
    logic [memtest_pkg::WORD_W-1:0] iter_cnt;    // Burst number, wraps.

    //////////////////// Counters.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            burst_addr <= '0;
            iter_cnt   <= '0;
        end else if (advance) begin
            burst_addr <= burst_addr + memtest_pkg::BURST_WORDS;  // Four-word step.
            iter_cnt   <= iter_cnt + memtest_pkg::PATTERN_STEP;
        end
    end

    assign mem_addr = burst_addr;

    // Each lane one step above the one before.
    // A lane swap then shows up as a mismatch.
    assign mem_wdata0 = iter_cnt;
    assign mem_wdata1 = mem_wdata0 + memtest_pkg::PATTERN_STEP;
    assign mem_wdata2 = mem_wdata1 + memtest_pkg::PATTERN_STEP;
    assign mem_wdata3 = mem_wdata2 + memtest_pkg::PATTERN_STEP;

    // Exact match on the last burst start.
    assign last_burst = (burst_addr == REGION_WORDS - memtest_pkg::BURST_WORDS);

endmodule

`default_nettype wire

/* hdl/memtest_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module memtest_ctrl #(
    parameter int unsigned PAUSE_CYCLES = memtest_pkg::DEFAULT_PAUSE_CYCLES
) (
    input  wire        clk_133MHz_210,
    input  wire        rst_n,
    input  wire        mem_wr_done,   // One-cycle pulse from memory.
    input  wire        mem_rd_done,   // One-cycle pulse, read data valid.
    input  wire        word_ok,       // Selected word matches.
    input  wire        last_burst,    // Final burst of the region.
    input  wire        tx_busy,
    output logic       mem_wr_req,    // Level, held until done.
    output logic       mem_rd_req,    // Level, held until done.
    output logic       advance,       // Step to next burst.
    output logic [2:0] byte_idx,      // Byte of burst being sent.
    output logic       tx_start,      // One-cycle pulse to UART.
    output logic       err_led,
    output logic       test_done
);

    memtest_pkg::memtest_state_e state;
    logic [31:0] pause_cnt;         // Cycles spent in pause.
    logic        last_byte;         // Byte 7 in flight.

    assign last_byte = (byte_idx == 3'(memtest_pkg::BYTES_PER_BURST - 1));

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= memtest_pkg::ST_WRITE;
            mem_wr_req <= 1'b0;
            mem_rd_req <= 1'b0;
            advance    <= 1'b0;
            byte_idx   <= 3'd0;
            tx_start   <= 1'b0;
            err_led    <= 1'b0;
            test_done  <= 1'b0;
            pause_cnt  <= 32'd0;
        end else begin
            advance  <= 1'b0;  // Pulses by default.
            tx_start <= 1'b0;

            case (state)
                //////////////////// Memory access.
                memtest_pkg::ST_WRITE: begin
                    if (mem_wr_done) begin
                        mem_wr_req <= 1'b0;  // Drop on edge after done.
                        state      <= memtest_pkg::ST_READ;
                    end else begin
                        mem_wr_req <= 1'b1;
                    end
                end

                memtest_pkg::ST_READ: begin
                    if (mem_rd_done) begin
                        mem_rd_req <= 1'b0;
                        byte_idx   <= 3'd0;  // Checker captures this cycle.
                        state      <= memtest_pkg::ST_CHECK;
                    end else begin
                        mem_rd_req <= 1'b1;
                    end
                end

                //////////////////// Compare and send.
                memtest_pkg::ST_CHECK: begin
                    if (word_ok) begin
                        tx_start <= 1'b1;
                        state    <= memtest_pkg::ST_SEND;
                    end else begin
                        state <= memtest_pkg::ST_FAIL;  // Nothing sent for this word.
                    end
                end

                memtest_pkg::ST_SEND: begin
                    state <= memtest_pkg::ST_WAIT_TX;  // tx_busy up next cycle.
                end

                memtest_pkg::ST_WAIT_TX: begin
                    if (!tx_busy) begin
                        if (last_byte) begin
                            state <= memtest_pkg::ST_PAUSE;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                            state    <= memtest_pkg::ST_CHECK;
                        end
                    end
                end

                //////////////////// Gap and wrap-up.
                memtest_pkg::ST_PAUSE: begin
                    if (pause_cnt == PAUSE_CYCLES - 1) begin
                        pause_cnt <= 32'd0;
                        if (last_burst) begin
                            state <= memtest_pkg::ST_DONE;
                        end else begin
                            advance <= 1'b1;  // New address lands with write request.
                            state   <= memtest_pkg::ST_WRITE;
                        end
                    end else begin
                        pause_cnt <= pause_cnt + 32'd1;
                    end
                end

                memtest_pkg::ST_FAIL: begin
                    err_led <= 1'b1;  // Stuck here until reset.
                end

                memtest_pkg::ST_DONE: begin
                    test_done <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // 133.333 MHz / 115200 baud.
    localparam logic [10:0] BAUD_DIVISOR = 11'd1157;

    localparam int DATA_BITS = 8;   // LSB first on the wire.
    localparam int STOP_BITS = 2;

    // Start bit, data bits, stop bits.
    localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;

endpackage

`default_nettype wire

/* hdl/memtest_pkg.sv */
`default_nettype none

package memtest_pkg;

    //////////////////// Memory port shape.
    localparam int ADDR_W = 24;                        // Bank(2) + row(13) + column(9).
    localparam int WORD_W = 16;                        // One SDRAM word.

    localparam logic [ADDR_W-1:0] BURST_WORDS = ADDR_W'(4);  // Words per burst.
    localparam int BYTES_PER_BURST = 8;                // Two bytes per word, high first.

    // Pattern rule. Lane k carries iteration count plus k.
    localparam logic [WORD_W-1:0] PATTERN_STEP = WORD_W'(1);

    //////////////////// Default run length.
    localparam logic [ADDR_W-1:0] DEFAULT_REGION_WORDS = ADDR_W'(384000);  // 480 x 800 frame.
    localparam int unsigned DEFAULT_PAUSE_CYCLES = 2222222;  // Roughly 16.7 ms at 133 MHz.

    // Tester FSM states.
    typedef enum logic [2:0] {
        ST_WRITE,    // Burst write, request held until done.
        ST_READ,     // Burst read back.
        ST_CHECK,    // Compare word of current byte.
        ST_SEND,     // Let the UART pick up the byte.
        ST_WAIT_TX,  // Frame on the wire.
        ST_PAUSE,    // Gap between bursts.
        ST_FAIL,     // Mismatch seen. Halt.
        ST_DONE      // Region finished. Halt.
    } memtest_state_e;

endpackage

`default_nettype wire
